//--- src/core_types_pkg.sv
/*
    Core-wide type definitions
    Widths and vector types for fetch PCs, local branch history
    and address-space IDs, shared by every front-end block.
*/

package core_types_pkg;

    // ----------------------------------------
    // Widths

    // Full virtual PC
    localparam int PC_WIDTH = 32;

    // Per-branch local history length
    localparam int LH_LENGTH = 8;

    // Address-space ID
    localparam int ASID_WIDTH = 9;

    // ----------------------------------------
    // Types

    typedef logic [PC_WIDTH-1:0]   pc_t;
    typedef logic [LH_LENGTH-1:0]  lh_t;
    typedef logic [ASID_WIDTH-1:0] asid_t;

endpackage

//--- src/lbpt_pkg.sv
/*
    LBPT definitions
    Table geometry, 2-bit counter encoding, the update request struct,
    and the index hash and counter training rules.
*/

package lbpt_pkg;

    // ----------------------------------------
    // Geometry

    localparam int LBPT_INDEX_BITS = 8;
    localparam int LBPT_ENTRIES    = 1 << LBPT_INDEX_BITS;

    // 2-bit saturating counter
    localparam int LBPT_COUNTER_BITS = 2;

    typedef logic [LBPT_INDEX_BITS-1:0]   lbpt_index_t;
    typedef logic [LBPT_COUNTER_BITS-1:0] lbpt_counter_t;

    // Weakly not-taken after reset
    localparam lbpt_counter_t LBPT_COUNTER_RESET = 2'b01;
    localparam lbpt_counter_t LBPT_COUNTER_MAX   = 2'b11;
    localparam lbpt_counter_t LBPT_COUNTER_MIN   = 2'b00;

    // Resolved branch heading into the update pipe
    typedef struct packed {
        logic        valid;
        lbpt_index_t index;
        logic        taken;
    } lbpt_update_t;

    // ----------------------------------------
    // Functions

    // PC[9:2] ^ LH ^ ASID[7:0]
    // Word-aligned PC bits drop the two always-zero bits
    function automatic lbpt_index_t lbpt_hash(
        input core_types_pkg::pc_t   pc,
        input core_types_pkg::lh_t   lh,
        input core_types_pkg::asid_t asid
    );
        return pc[LBPT_INDEX_BITS+1:2] ^ lh ^ asid[LBPT_INDEX_BITS-1:0];
    endfunction

    // Step toward the resolved direction, saturating at both ends
    function automatic lbpt_counter_t lbpt_train(
        input lbpt_counter_t counter,
        input logic          taken
    );
        lbpt_counter_t trained;
        trained = counter;
        if (taken && (counter != LBPT_COUNTER_MAX)) begin
            trained = counter + 2'd1;
        end else if (!taken && (counter != LBPT_COUNTER_MIN)) begin
            trained = counter - 2'd1;
        end
        return trained;
    endfunction

endpackage

//--- src/lbpt_counter_table.sv
/*
    LBPT counter table
    256 two-bit saturating counters with two registered read ports,
    one for prediction and one for update, plus one write port.
*/

`timescale 1ns/1ps

module lbpt_counter_table (
    input  logic                    CLK,
    input  logic                    nRST,
    input  lbpt_pkg::lbpt_index_t   pred_rd_index,
    input  lbpt_pkg::lbpt_index_t   upd_rd_index,
    input  lbpt_pkg::lbpt_index_t   wr_index,
    input  logic                    wr_en,
    input  lbpt_pkg::lbpt_counter_t wr_counter,
    output lbpt_pkg::lbpt_counter_t pred_rd_counter,
    output lbpt_pkg::lbpt_counter_t upd_rd_counter
);

    import lbpt_pkg::*;

    // Counter storage
    lbpt_counter_t counters [LBPT_ENTRIES];

    // ----------------------------------------
    // Write port

    // Whole array back to weakly not-taken on reset
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < LBPT_ENTRIES; i++) begin
                counters[i] <= LBPT_COUNTER_RESET;
            end
        end else if (wr_en) begin
            counters[wr_index] <= wr_counter;
        end
    end

    // ----------------------------------------
    // Read ports

    // Both ports sample the array before this edge's write lands
    // Same-index read and write returns the old counter
    always_ff @(posedge CLK) begin
        pred_rd_counter <= counters[pred_rd_index];
        upd_rd_counter  <= counters[upd_rd_index];
    end

    // ----------------------------------------
    // Checks

    // Write index from the update pipe must be fully known
    a_wr_index_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        wr_en |-> !$isunknown(wr_index)
    );

endmodule

//--- src/lbpt_update_pipe.sv
/*
    LBPT update pipe
    Update 0 reads the old counter, Update 1 trains it and writes it
    back, forwarding the previous write on back-to-back hits.
*/

`timescale 1ns/1ps

module lbpt_update_pipe (
    input  logic                    CLK,
    input  logic                    nRST,
    input  lbpt_pkg::lbpt_update_t  update0,
    output lbpt_pkg::lbpt_index_t   upd_rd_index,
    input  lbpt_pkg::lbpt_counter_t upd_rd_counter,
    output logic                    wr_en,
    output lbpt_pkg::lbpt_index_t   wr_index,
    output lbpt_pkg::lbpt_counter_t wr_counter,
    output logic                    update1_correct
);

    import lbpt_pkg::*;

    // Update 1 stage request
    lbpt_update_t  update1;

    // Write issued at the previous edge, not yet visible in read data
    logic          fwd_valid;
    lbpt_index_t   fwd_index;
    lbpt_counter_t fwd_counter;

    // Counter the Update 1 branch trains on
    logic          fwd_hit;
    lbpt_counter_t old_counter;

    // ----------------------------------------
    // Update 0

    // Table read launches alongside the stage register
    assign upd_rd_index = update0.index;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            update1 <= '0;
        end else begin
            update1 <= update0;
        end
    end

    // ----------------------------------------
    // Update 1

    // Read and write at the same edge returned stale data
    assign fwd_hit     = fwd_valid && (fwd_index == update1.index);
    assign old_counter = fwd_hit ? fwd_counter : upd_rd_counter;

    assign wr_en      = update1.valid;
    assign wr_index   = update1.index;
    assign wr_counter = lbpt_train(old_counter, update1.taken);

    // Upper bit is the prediction the old counter would have made
    assign update1_correct = update1.valid && (old_counter[1] == update1.taken);

    // Pending write tracking
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            fwd_valid <= 1'b0;
        end else begin
            fwd_valid <= wr_en;
        end
    end

    always_ff @(posedge CLK) begin
        fwd_index   <= wr_index;
        fwd_counter <= wr_counter;
    end

    // ----------------------------------------
    // Checks

    // A write carries a complete Update 1 request and a known old counter
    a_wr_update1_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        wr_en |-> !$isunknown({update1.index, update1.taken, old_counter})
    );

endmodule

//--- src/lbpt.sv
/*
    Local branch prediction table
    Hashes prediction and update requests into table indices,
    returns RESP predictions in RESTART and trains counters.
*/

`timescale 1ns/1ps

module lbpt (
    input  logic                  CLK,
    input  logic                  nRST,

    // RESP stage
    input  logic                  valid_RESP,
    input  core_types_pkg::pc_t   full_PC_RESP,
    input  core_types_pkg::lh_t   LH_RESP,
    input  core_types_pkg::asid_t ASID_RESP,

    // RESTART stage
    output logic                  pred_taken_RESTART,

    // Update 0
    input  logic                  update0_valid,
    input  core_types_pkg::pc_t   update0_start_full_PC,
    input  core_types_pkg::lh_t   update0_LH,
    input  core_types_pkg::asid_t update0_ASID,
    input  logic                  update0_taken,

    // Update 1
    output logic                  update1_correct
);

    import lbpt_pkg::*;

    // Prediction path
    lbpt_index_t   pred_index_RESP;
    logic          valid_RESTART;
    lbpt_counter_t pred_counter_RESTART;

    // Update path
    lbpt_update_t  update0;
    lbpt_index_t   upd_rd_index;
    lbpt_counter_t upd_rd_counter;

    // Table write
    logic          wr_en;
    lbpt_index_t   wr_index;
    lbpt_counter_t wr_counter;

    // ----------------------------------------
    // Prediction

    assign pred_index_RESP = lbpt_hash(full_PC_RESP, LH_RESP, ASID_RESP);

    // Valid follows the table read into RESTART
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_RESTART <= 1'b0;
        end else begin
            valid_RESTART <= valid_RESP;
        end
    end

    // Taken when counter MSB set, held low with no request
    assign pred_taken_RESTART = valid_RESTART && pred_counter_RESTART[1];

    // ----------------------------------------
    // Update request

    assign update0.valid = update0_valid;
    assign update0.index = lbpt_hash(update0_start_full_PC, update0_LH, update0_ASID);
    assign update0.taken = update0_taken;

    // ----------------------------------------
    // Submodules

    lbpt_counter_table counter_table_i (
        .CLK             (CLK),
        .nRST            (nRST),
        .pred_rd_index   (pred_index_RESP),
        .upd_rd_index    (upd_rd_index),
        .wr_index        (wr_index),
        .wr_en           (wr_en),
        .wr_counter      (wr_counter),
        .pred_rd_counter (pred_counter_RESTART),
        .upd_rd_counter  (upd_rd_counter)
    );

    lbpt_update_pipe update_pipe_i (
        .CLK             (CLK),
        .nRST            (nRST),
        .update0         (update0),
        .upd_rd_index    (upd_rd_index),
        .upd_rd_counter  (upd_rd_counter),
        .wr_en           (wr_en),
        .wr_index        (wr_index),
        .wr_counter      (wr_counter),
        .update1_correct (update1_correct)
    );

endmodule

//--- src/lbpt_wrapper.sv
/*
    LBPT top-level wrapper
    Registers every input and output around the LBPT core so the
    block boundary is flop-to-flop.
*/

`timescale 1ns/1ps

module lbpt_wrapper (
    input  logic                  CLK,
    input  logic                  nRST,

    // RESP stage
    input  logic                  next_valid_RESP,
    input  core_types_pkg::pc_t   next_full_PC_RESP,
    input  core_types_pkg::lh_t   next_LH_RESP,
    input  core_types_pkg::asid_t next_ASID_RESP,

    // RESTART stage
    output logic                  last_pred_taken_RESTART,

    // Update 0
    input  logic                  next_update0_valid,
    input  core_types_pkg::pc_t   next_update0_start_full_PC,
    input  core_types_pkg::lh_t   next_update0_LH,
    input  core_types_pkg::asid_t next_update0_ASID,
    input  logic                  next_update0_taken,

    // Update 1
    output logic                  last_update1_correct
);

    import core_types_pkg::*;

    // ----------------------------------------
    // Registered core-side signals

    logic  valid_RESP;
    pc_t   full_PC_RESP;
    lh_t   LH_RESP;
    asid_t ASID_RESP;
    logic  pred_taken_RESTART;

    logic  update0_valid;
    pc_t   update0_start_full_PC;
    lh_t   update0_LH;
    asid_t update0_ASID;
    logic  update0_taken;
    logic  update1_correct;

    // ----------------------------------------
    // Core

    lbpt wrapped_module (
        .CLK                   (CLK),
        .nRST                  (nRST),
        .valid_RESP            (valid_RESP),
        .full_PC_RESP          (full_PC_RESP),
        .LH_RESP               (LH_RESP),
        .ASID_RESP             (ASID_RESP),
        .pred_taken_RESTART    (pred_taken_RESTART),
        .update0_valid         (update0_valid),
        .update0_start_full_PC (update0_start_full_PC),
        .update0_LH            (update0_LH),
        .update0_ASID          (update0_ASID),
        .update0_taken         (update0_taken),
        .update1_correct       (update1_correct)
    );

    // ----------------------------------------
    // Boundary registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // RESP inputs
            valid_RESP              <= 1'b0;
            full_PC_RESP            <= '0;
            LH_RESP                 <= '0;
            ASID_RESP               <= '0;
            // Update 0 inputs
            update0_valid           <= 1'b0;
            update0_start_full_PC   <= '0;
            update0_LH              <= '0;
            update0_ASID            <= '0;
            update0_taken           <= 1'b0;
            // Outputs
            last_pred_taken_RESTART <= 1'b0;
            last_update1_correct    <= 1'b0;
        end else begin
            valid_RESP              <= next_valid_RESP;
            full_PC_RESP            <= next_full_PC_RESP;
            LH_RESP                 <= next_LH_RESP;
            ASID_RESP               <= next_ASID_RESP;
            update0_valid           <= next_update0_valid;
            update0_start_full_PC   <= next_update0_start_full_PC;
            update0_LH              <= next_update0_LH;
            update0_ASID            <= next_update0_ASID;
            update0_taken           <= next_update0_taken;
            last_pred_taken_RESTART <= pred_taken_RESTART;
            last_update1_correct    <= update1_correct;
        end
    end

endmodule

//--- tests/lbpt_wrapper_tb.sv
/*
    LBPT wrapper testbench
    Table-driven and random predictions and updates, checked against
    a 256-entry counter model at the fixed wrapper latency.
*/

`timescale 1ns/1ps

module lbpt_wrapper_tb;

    import core_types_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int LATENCY      = 3;
    localparam int NUM_ROWS     = 20;
    localparam int RANDOM_REQS  = 200;
    localparam int WAIT_LIMIT   = 20;

    typedef struct packed {
        logic  is_upd;
        logic  b2b;
        pc_t   pc;
        lh_t   lh;
        asid_t asid;
        logic  taken;
        logic  exp;
    } row_t;

    // Result due at a given negedge count
    typedef struct packed {
        int   due;
        int   tag;
        logic is_upd;
        logic exp;
    } pending_t;

    logic  CLK;
    logic  nRST;
    logic  next_valid_RESP;
    pc_t   next_full_PC_RESP;
    lh_t   next_LH_RESP;
    asid_t next_ASID_RESP;
    logic  last_pred_taken_RESTART;
    logic  next_update0_valid;
    pc_t   next_update0_start_full_PC;
    lh_t   next_update0_LH;
    asid_t next_update0_ASID;
    logic  next_update0_taken;
    logic  last_update1_correct;

    logic [1:0] model [256];
    pending_t   pending [$];
    int         cyc;
    int         errors;
    int         checks;
    int         tests_run;
    int         tests_failed;
    int         random_errors;

    // is_upd, b2b, pc, lh, asid, taken, expected output
    // Update rows expect the correct flag, predict rows the taken bit
    row_t stim [NUM_ROWS] = '{
        '{1'b0, 1'b0, 32'h0000_1000, 8'h00, 9'h000, 1'b0, 1'b0},
        '{1'b0, 1'b0, 32'h0000_03fc, 8'h00, 9'h000, 1'b0, 1'b0},
        '{1'b1, 1'b0, 32'h0000_0040, 8'h03, 9'h000, 1'b1, 1'b0},
        '{1'b1, 1'b0, 32'h0000_0040, 8'h03, 9'h000, 1'b1, 1'b1},
        '{1'b0, 1'b0, 32'h0000_0040, 8'h03, 9'h000, 1'b0, 1'b1},
        '{1'b1, 1'b0, 32'h0000_0040, 8'h03, 9'h000, 1'b0, 1'b0},
        '{1'b1, 1'b0, 32'h0000_0040, 8'h03, 9'h000, 1'b0, 1'b0},
        '{1'b0, 1'b0, 32'h0000_0040, 8'h03, 9'h000, 1'b0, 1'b0},
        '{1'b1, 1'b0, 32'h0000_0100, 8'h00, 9'h005, 1'b1, 1'b0},
        '{1'b1, 1'b1, 32'h0000_0100, 8'h00, 9'h005, 1'b1, 1'b1},
        '{1'b1, 1'b1, 32'h0000_0100, 8'h00, 9'h005, 1'b1, 1'b1},
        '{1'b1, 1'b0, 32'h0000_0100, 8'h00, 9'h005, 1'b0, 1'b0},
        '{1'b0, 1'b0, 32'h0000_0100, 8'h00, 9'h005, 1'b0, 1'b1},
        '{1'b0, 1'b0, 32'h0000_0000, 8'h40, 9'h105, 1'b0, 1'b1},
        '{1'b1, 1'b0, 32'h0000_0114, 8'h00, 9'h000, 1'b0, 1'b0},
        '{1'b0, 1'b0, 32'h0000_0100, 8'h00, 9'h005, 1'b0, 1'b0},
        '{1'b1, 1'b0, 32'h0000_0044, 8'h02, 9'h000, 1'b1, 1'b0},
        '{1'b0, 1'b0, 32'h0000_0040, 8'h03, 9'h000, 1'b0, 1'b1},
        '{1'b1, 1'b0, 32'h0000_0040, 8'h02, 9'h000, 1'b0, 1'b1},
        '{1'b0, 1'b0, 32'h0000_0040, 8'h03, 9'h000, 1'b0, 1'b1}
    };

    lbpt_wrapper dut_i (.*);

    always #50 CLK = ~CLK;

    // ----------------------------------------
    // Reference model

    // PC word bits, history and low ASID byte folded together
    function automatic logic [7:0] ref_index(input pc_t pc, input lh_t lh, input asid_t asid);
        return pc[9:2] ^ lh ^ asid[7:0];
    endfunction

    // Expected output, training the model counter on updates
    function automatic logic model_step(input logic is_upd, input logic [7:0] idx,
                                        input logic taken);
        logic [1:0] c;
        c = model[idx];
        if (!is_upd) begin
            return c[1];
        end
        if (taken && (c != 2'b11)) begin
            model[idx] = c + 2'd1;
        end else if (!taken && (c != 2'b00)) begin
            model[idx] = c - 2'd1;
        end
        return c[1] == taken;
    endfunction

    // ----------------------------------------
    // Driving and checking

    task automatic check_due();
        pending_t p;
        logic     got;
        logic     other;
        logic     ok;
        while ((pending.size() > 0) && (pending[0].due == cyc)) begin
            p     = pending.pop_front();
            got   = p.is_upd ? last_update1_correct : last_pred_taken_RESTART;
            other = p.is_upd ? last_pred_taken_RESTART : last_update1_correct;
            ok    = (got === p.exp) && (other === 1'b0);
            checks++;
            assert (ok) else begin
                $display("[FAIL] %0t: %s tag %0d got %b (other output %b), expected %b",
                         $time, p.is_upd ? "update" : "predict", p.tag, got, other, p.exp);
                errors++;
            end
            if (p.tag >= 0) begin
                tests_run++;
                tests_failed += ok ? 0 : 1;
                $display("row %0d %s: %s", p.tag, p.is_upd ? "update " : "predict",
                         ok ? "PASS" : "FAIL");
            end else if (!ok) begin
                random_errors++;
            end
        end
    endtask

    // One cycle; valids drop unless the caller drives again
    task automatic tick();
        @(negedge CLK);
        cyc++;
        check_due();
        next_valid_RESP    = 1'b0;
        next_update0_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((pending.size() > 0) && (waited <= WAIT_LIMIT)) begin
            tick();
            waited++;
        end
        if (pending.size() > 0) begin
            $display("Timed out with %0d results never checked", pending.size());
            $display("Test failures found");
            $finish;
        end
    endtask

    task automatic issue(input logic is_upd, input pc_t pc, input lh_t lh, input asid_t asid,
                         input logic taken, input logic exp, input int tag);
        pending_t p;
        p.due    = cyc + LATENCY;
        p.tag    = tag;
        p.is_upd = is_upd;
        p.exp    = exp;
        pending.push_back(p);
        if (is_upd) begin
            next_update0_valid         = 1'b1;
            next_update0_start_full_PC = pc;
            next_update0_LH            = lh;
            next_update0_ASID          = asid;
            next_update0_taken         = taken;
        end else begin
            next_valid_RESP   = 1'b1;
            next_full_PC_RESP = pc;
            next_LH_RESP      = lh;
            next_ASID_RESP    = asid;
        end
    endtask

    // ----------------------------------------
    // Sequence

    initial begin
        logic  is_upd;
        pc_t   pc;
        lh_t   lh;
        asid_t asid;
        logic  taken;
        logic  exp;
        int    reset_errs;
        void'($urandom(89));
        CLK = 1'b0;
        nRST = 1'b0;
        next_valid_RESP = 1'b0;
        next_full_PC_RESP = '0;
        next_LH_RESP = '0;
        next_ASID_RESP = '0;
        next_update0_valid = 1'b0;
        next_update0_start_full_PC = '0;
        next_update0_LH = '0;
        next_update0_ASID = '0;
        next_update0_taken = 1'b0;
        cyc = 0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        random_errors = 0;
        reset_errs = 0;
        for (int i = 0; i < 256; i++) begin
            model[i] = 2'b01;
        end

        // Both outputs low throughout reset
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge CLK);
            checks++;
            assert ((last_pred_taken_RESTART === 1'b0) && (last_update1_correct === 1'b0))
            else begin
                $display("[FAIL] %0t: outputs not low during reset", $time);
                errors++;
                reset_errs++;
            end
        end
        nRST = 1'b1;
        tests_run++;
        tests_failed += (reset_errs == 0) ? 0 : 1;
        $display("reset: %s", (reset_errs == 0) ? "PASS" : "FAIL");

        // Directed table
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!stim[r].b2b) begin
                drain();
            end
            tick();
            exp = model_step(stim[r].is_upd, ref_index(stim[r].pc, stim[r].lh, stim[r].asid),
                             stim[r].taken);
            assert (exp === stim[r].exp) else begin
                $display("Reference model and stimulus table disagree at row %0d", r);
                errors++;
            end
            issue(stim[r].is_upd, stim[r].pc, stim[r].lh, stim[r].asid, stim[r].taken,
                  stim[r].exp, r);
        end
        drain();

        // Random mix, PC[9:5] cleared so indices collide often
        for (int n = 0; n < RANDOM_REQS; n++) begin
            drain();
            tick();
            is_upd = 1'($urandom_range(0, 1));
            pc     = $urandom & 32'hffff_fc1f;
            lh     = 8'($urandom_range(0, 7));
            asid   = 9'($urandom) & 9'h103;
            taken  = 1'($urandom_range(0, 1));
            exp    = model_step(is_upd, ref_index(pc, lh, asid), taken);
            issue(is_upd, pc, lh, asid, taken, exp, -1);
        end
        drain();
        tests_run++;
        tests_failed += (random_errors == 0) ? 0 : 1;
        $display("random mix of %0d requests: %s", RANDOM_REQS,
                 (random_errors == 0) ? "PASS" : "FAIL");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- lbpt.f
src/core_types_pkg.sv
src/lbpt_pkg.sv
src/lbpt_counter_table.sv
src/lbpt_update_pipe.sv
src/lbpt.sv
src/lbpt_wrapper.sv
tests/lbpt_wrapper_tb.sv

//--- Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert
LINT      := --lint-only --timing -Wall
TOP       := lbpt_wrapper_tb
RTL_TOP   := lbpt_wrapper
FILELIST  := lbpt.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o sim

run: build
	./$(BUILD_DIR)/sim | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
